/* include/qelem_defs.svh */
// qelem widths, depths and pipeline latencies shared by all blocks
`ifndef QELEM_DEFS_SVH
`define QELEM_DEFS_SVH

`define QE_NSLICE       2    // samples per clock
`define QE_NELEM        2    // pulse elements, element_sum takes exactly two
`define QE_TBL_AW       8    // envelope and frequency table address width
`define QE_LEN_W        8    // envelope length width
`define QE_SHIFT_W      5    // accumulator output shift

// pipeline latencies
`define QE_GATE_DLY     1    // address gate to table data
`define QE_MOD_TAIL     3    // modulator stages behind the data gate
`define QE_MIX_GATE_DLY 5    // drive valid to slice sum in the mixer

`define QE_ACC_W        40   // mixer accumulator width

`endif

/* src/qelem_pkg.sv */
// qelem package with the sample, command and table-write types
`default_nettype none
`include "qelem_defs.svh"

package qelem_pkg;

	typedef struct packed {
		logic signed [15:0] x; // cos for a carrier word
		logic signed [15:0] y; // sin for a carrier word
	} iq16_t;

	typedef iq16_t [`QE_NSLICE-1:0] slice_vec_t; // one table word or drive sample

	typedef enum logic {
		TBL_ENV  = 1'b0,
		TBL_FREQ = 1'b1
	} tbl_sel_e;

	typedef struct packed {
		logic [`QE_TBL_AW-1:0] env_start;
		logic [`QE_LEN_W-1:0]  env_length;
		logic [`QE_TBL_AW-1:0] freq_addr;
		logic signed [15:0]    amp;
		logic                  elem_sel;
		logic                  strobe;
	} elem_cmd_t;

	typedef struct packed {
		logic                  we;
		logic                  elem_sel;
		tbl_sel_e              tbl_sel;
		logic [`QE_TBL_AW-1:0] addr;
		slice_vec_t            data;
	} tbl_wr_t;

	typedef struct packed {
		logic       valid;
		slice_vec_t data;
	} drive_t;

	typedef struct packed {
		logic signed [31:0] x;
		logic signed [31:0] y;
	} acc_t;

endpackage

`default_nettype wire

/* src/delay_line.sv */
// delay_line shifts any payload through a fixed chain of cleared registers
`default_nettype none

module delay_line #(
	parameter type payload_t = logic,
	parameter int  LEN       = 1
) (
	input  wire logic elem,
	input  wire logic reset,
	input  payload_t  din,
	output payload_t  dout
);

	payload_t stage [LEN];

	always_ff @(posedge elem) begin
		if (reset) begin
			for (int i = 0; i < LEN; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= din;
			for (int i = 1; i < LEN; i++) begin
				stage[i] <= stage[i-1]; // one cycle per stage
			end
		end
	end

	assign dout = stage[LEN-1];

endmodule

`default_nettype wire

/* src/wave_table.sv */
// wave_table holds envelope or carrier words with a host write port and registered read
`default_nettype none
`include "qelem_defs.svh"

module wave_table #(
	parameter type word_t = logic [31:0]
) (
	input  wire logic                  elem,
	input  wire logic                  we,
	input  wire logic [`QE_TBL_AW-1:0] waddr,
	input  word_t                      wdata,
	input  wire logic [`QE_TBL_AW-1:0] raddr,
	output word_t                      rdata
);

	localparam int DEPTH = 1 << `QE_TBL_AW;

	word_t mem [DEPTH];

	// host side
	always_ff @(posedge elem) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	always_ff @(posedge elem) begin
		rdata <= mem[raddr]; // data one cycle after the address
	end

endmodule

`default_nettype wire

/* src/env_sequencer.sv */
// env_sequencer walks the envelope addresses of one pulse and tracks its busy window
`default_nettype none
`include "qelem_defs.svh"

module env_sequencer import qelem_pkg::*; (
	input  wire logic                   elem,
	input  wire logic                   reset,
	input  wire logic                   start,
	input  elem_cmd_t                   cmd,
	output logic      [`QE_TBL_AW-1:0]  env_addr,
	output logic      [`QE_TBL_AW-1:0]  freq_addr,
	output logic                        gate,
	output logic                        busy
);

	logic [`QE_TBL_AW-1:0]   start_r;
	logic [`QE_LEN_W-1:0]    len_r;
	logic [`QE_TBL_AW-1:0]   addr_cnt;
	logic                    active;   // counter walking
	logic                    addr_gate; // env_addr is a pulse address
	logic                    last_addr;
	logic [`QE_MOD_TAIL-1:0] tail;     // gate copies through the modulator

	assign last_addr = addr_cnt == `QE_TBL_AW'(start_r + len_r - 1'b1);

	// command capture, the frequency address is held for the pulse
	always_ff @(posedge elem) begin
		if (start) begin
			start_r   <= cmd.env_start;
			len_r     <= cmd.env_length;
			freq_addr <= cmd.freq_addr;
		end
	end

	always_ff @(posedge elem) begin
		if (reset) begin
			active <= 1'b0;
		end else if (start) begin
			active <= |cmd.env_length; // zero length never runs
		end else if (active && last_addr) begin
			active <= 1'b0;
		end
	end

	always_ff @(posedge elem) begin
		if (start) begin
			addr_cnt <= cmd.env_start;
		end else if (active) begin
			addr_cnt <= addr_cnt + 1'b1;
		end
		env_addr <= addr_cnt;
	end

	always_ff @(posedge elem) begin
		if (reset) begin
			addr_gate <= 1'b0;
			tail      <= '0;
		end else begin
			addr_gate <= active;
			tail      <= {tail[`QE_MOD_TAIL-2:0], gate};
		end
	end

	// gate lines up with the table read data
	delay_line #(
		.payload_t(logic),
		.LEN      (`QE_GATE_DLY)
	) i_gate_dly (
		.elem (elem),
		.reset(reset),
		.din  (addr_gate),
		.dout (gate)
	);

	assign busy = addr_gate | gate | (|tail);

	a_no_restart: assert property (@(posedge elem) disable iff (reset)
		start |-> !busy);

	// table data reaches the gate three edges after the command
	a_gate_from_start: assert property (@(posedge elem) disable iff (reset)
		$rose(gate) |-> $past(start, 3));

endmodule

`default_nettype wire

/* src/am_modulator.sv */
// am_modulator multiplies each envelope slice by its carrier and scales by the amplitude
`default_nettype none
`include "qelem_defs.svh"

module am_modulator import qelem_pkg::*; (
	input  wire logic         elem,
	input  wire logic         reset,
	input  wire logic         gate,
	input  slice_vec_t        env,
	input  slice_vec_t        carrier,
	input  wire logic signed [15:0] amp,
	output drive_t            out
);

	logic signed [32:0] p1x [`QE_NSLICE]; // complex product
	logic signed [32:0] p1y [`QE_NSLICE];
	logic signed [33:0] p2x [`QE_NSLICE]; // scaled by amp
	logic signed [33:0] p2y [`QE_NSLICE];
	slice_vec_t         out_data;
	logic               g1;
	logic               g2;
	logic               out_valid;

	always_ff @(posedge elem) begin
		for (int i = 0; i < `QE_NSLICE; i++) begin
			// stage 1
			p1x[i] <= env[i].x * carrier[i].x - env[i].y * carrier[i].y;
			p1y[i] <= env[i].x * carrier[i].y + env[i].y * carrier[i].x;
			// stage 2, back to q15 then amplitude
			p2x[i] <= (p1x[i] >>> 15) * amp;
			p2y[i] <= (p1y[i] >>> 15) * amp;
			// stage 3
			out_data[i].x <= 16'(p2x[i] >>> 15);
			out_data[i].y <= 16'(p2y[i] >>> 15);
		end
	end

	// gate follows the data through the three stages
	always_ff @(posedge elem) begin
		if (reset) begin
			g1        <= 1'b0;
			g2        <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			g1        <= gate;
			g2        <= g1;
			out_valid <= g2;
		end
	end

	assign out = '{valid: out_valid, data: out_data};

endmodule

`default_nettype wire

/* src/pulse_element.sv */
// pulse_element plays one envelope against one carrier word at a captured amplitude
`default_nettype none
`include "qelem_defs.svh"

module pulse_element import qelem_pkg::*; #(
	parameter int INDEX = 0
) (
	input  wire logic elem,
	input  wire logic reset,
	input  wire logic start,
	input  elem_cmd_t cmd,
	input  tbl_wr_t   wr,
	output drive_t    out,
	output logic      busy
);

	logic [`QE_TBL_AW-1:0] env_addr;
	logic [`QE_TBL_AW-1:0] freq_addr;
	logic                  gate;
	logic                  env_we;
	logic                  freq_we;
	slice_vec_t            env_word;
	slice_vec_t            carrier_word;
	logic signed [15:0]    amp_r;

	assign env_we  = wr.we && (wr.elem_sel == 1'(INDEX)) && (wr.tbl_sel == TBL_ENV);
	assign freq_we = wr.we && (wr.elem_sel == 1'(INDEX)) && (wr.tbl_sel == TBL_FREQ);

	always_ff @(posedge elem) begin
		if (start) begin
			amp_r <= cmd.amp; // constant for the whole pulse
		end
	end

	env_sequencer i_env_sequencer (
		.elem     (elem),
		.reset    (reset),
		.start    (start),
		.cmd      (cmd),
		.env_addr (env_addr),
		.freq_addr(freq_addr),
		.gate     (gate),
		.busy     (busy)
	);

	wave_table #(.word_t(slice_vec_t)) i_env_table (
		.elem (elem),
		.we   (env_we),
		.waddr(wr.addr),
		.wdata(wr.data),
		.raddr(env_addr),
		.rdata(env_word)
	);

	wave_table #(.word_t(slice_vec_t)) i_freq_table (
		.elem (elem),
		.we   (freq_we),
		.waddr(wr.addr),
		.wdata(wr.data),
		.raddr(freq_addr),
		.rdata(carrier_word)
	);

	am_modulator i_am_modulator (
		.elem   (elem),
		.reset  (reset),
		.gate   (gate),
		.env    (env_word),
		.carrier(carrier_word),
		.amp    (amp_r),
		.out    (out)
	);

endmodule

`default_nettype wire

/* src/element_sum.sv */
// element_sum adds the two element outputs slice by slice with 16-bit wraparound
`default_nettype none
`include "qelem_defs.svh"

module element_sum import qelem_pkg::*; (
	input  wire logic elem,
	input  wire logic reset,
	input  drive_t    in0,
	input  drive_t    in1,
	output drive_t    sum
);

	slice_vec_t in0_r;
	slice_vec_t in1_r;
	slice_vec_t sum_r;
	logic       valid0;
	logic       valid1;

	always_ff @(posedge elem) begin
		in0_r <= in0.valid ? in0.data : '0; // an idle element adds nothing
		in1_r <= in1.valid ? in1.data : '0;
		for (int i = 0; i < `QE_NSLICE; i++) begin
			// overflow wraps, amplitudes are the host's job
			sum_r[i].x <= in0_r[i].x + in1_r[i].x;
			sum_r[i].y <= in0_r[i].y + in1_r[i].y;
		end
	end

	always_ff @(posedge elem) begin
		if (reset) begin
			valid0 <= 1'b0;
			valid1 <= 1'b0;
		end else begin
			valid0 <= in0.valid | in1.valid;
			valid1 <= valid0;
		end
	end

	assign sum = '{valid: valid1, data: sum_r};

endmodule

`default_nettype wire

/* src/mix_accumulator.sv */
// mix_accumulator multiplies adc by drive, sums over the pulse and strobes the shifted totals
`default_nettype none
`include "qelem_defs.svh"

module mix_accumulator import qelem_pkg::*; (
	input  wire logic                   elem,
	input  wire logic                   reset,
	input  slice_vec_t                  adc,
	input  drive_t                      drive,
	input  wire logic [`QE_SHIFT_W-1:0] shift,
	output acc_t                        acc,
	output logic                        acc_stb
);

	localparam int SUM_W = 33 + $clog2(`QE_NSLICE);

	slice_vec_t                  adc_r;
	slice_vec_t                  drv_r;
	logic signed [15:0]          ax [`QE_NSLICE];
	logic signed [15:0]          ay [`QE_NSLICE];
	logic signed [15:0]          dx [`QE_NSLICE];
	logic signed [15:0]          dy [`QE_NSLICE];
	logic signed [31:0]          pp_xx [`QE_NSLICE];
	logic signed [31:0]          pp_yy [`QE_NSLICE];
	logic signed [31:0]          pp_xy [`QE_NSLICE];
	logic signed [31:0]          pp_yx [`QE_NSLICE];
	logic signed [32:0]          px [`QE_NSLICE];
	logic signed [32:0]          py [`QE_NSLICE];
	logic signed [SUM_W-1:0]     slice_sum_x_c;
	logic signed [SUM_W-1:0]     slice_sum_y_c;
	logic signed [SUM_W-1:0]     slice_sum_x;
	logic signed [SUM_W-1:0]     slice_sum_y;
	logic signed [`QE_ACC_W-1:0] acc_x;
	logic signed [`QE_ACC_W-1:0] acc_y;
	logic                        gate_d;  // in step with slice_sum
	logic                        gate_dd;

	always_ff @(posedge elem) begin
		adc_r <= adc;
		drv_r <= drive.data;
		for (int i = 0; i < `QE_NSLICE; i++) begin
			ax[i] <= adc_r[i].x; // operand stage
			ay[i] <= adc_r[i].y;
			dx[i] <= drv_r[i].x;
			dy[i] <= drv_r[i].y;
			pp_xx[i] <= ax[i] * dx[i];
			pp_yy[i] <= ay[i] * dy[i];
			pp_xy[i] <= ax[i] * dy[i];
			pp_yx[i] <= ay[i] * dx[i];
			px[i] <= pp_xx[i] - pp_yy[i];
			py[i] <= pp_xy[i] + pp_yx[i];
		end
	end

	always_comb begin
		slice_sum_x_c = '0;
		slice_sum_y_c = '0;
		for (int i = 0; i < `QE_NSLICE; i++) begin
			slice_sum_x_c = slice_sum_x_c + px[i];
			slice_sum_y_c = slice_sum_y_c + py[i];
		end
	end

	// first sample of a pulse restarts the sum
	always_ff @(posedge elem) begin
		slice_sum_x <= slice_sum_x_c;
		slice_sum_y <= slice_sum_y_c;
		if (gate_d && !gate_dd) begin
			acc_x <= slice_sum_x;
			acc_y <= slice_sum_y;
		end else if (gate_d) begin
			acc_x <= acc_x + slice_sum_x;
			acc_y <= acc_y + slice_sum_y;
		end
	end

	delay_line #(
		.payload_t(logic),
		.LEN      (`QE_MIX_GATE_DLY)
	) i_gate_dly (
		.elem (elem),
		.reset(reset),
		.din  (drive.valid),
		.dout (gate_d)
	);

	always_ff @(posedge elem) begin
		if (reset) begin
			gate_dd <= 1'b0;
			acc_stb <= 1'b0;
			acc     <= '0;
		end else begin
			gate_dd <= gate_d;
			acc_stb <= gate_dd && !gate_d; // last sample is in acc_x
			if (gate_dd && !gate_d) begin
				acc.x <= 32'(acc_x >>> shift);
				acc.y <= 32'(acc_y >>> shift);
			end
		end
	end

	a_stb_single: assert property (@(posedge elem) disable iff (reset)
		acc_stb |=> !acc_stb);

	// strobe lands six cycles behind the end of the drive
	a_stb_after_drive: assert property (@(posedge elem) disable iff (reset)
		acc_stb |-> $past($fell(drive.valid), 6));

endmodule

`default_nettype wire

/* src/qelem_top.sv */
// qelem top level with two pulse elements, their summer and the mixing accumulator
`default_nettype none
`include "qelem_defs.svh"

module qelem_top import qelem_pkg::*; (
	input  wire logic                   elem,
	input  wire logic                   reset,
	input  elem_cmd_t                   cmd,
	input  tbl_wr_t                     wr,
	input  slice_vec_t                  adc,
	input  wire logic [`QE_SHIFT_W-1:0] shift,
	output drive_t                      drive,
	output logic      [`QE_NELEM-1:0]   elem_busy,
	output acc_t                        acc,
	output logic                        acc_stb
);

	logic   [`QE_NELEM-1:0] start;
	drive_t                 elem_out [`QE_NELEM];

	for (genvar i = 0; i < `QE_NELEM; i++) begin : g_elem
		// command strobe goes to the selected element only
		assign start[i] = cmd.strobe && (cmd.elem_sel == 1'(i));

		pulse_element #(.INDEX(i)) i_pulse_element (
			.elem (elem),
			.reset(reset),
			.start(start[i]),
			.cmd  (cmd),
			.wr   (wr),
			.out  (elem_out[i]),
			.busy (elem_busy[i])
		);
	end

	element_sum i_element_sum (
		.elem (elem),
		.reset(reset),
		.in0  (elem_out[0]),
		.in1  (elem_out[1]),
		.sum  (drive)
	);

	mix_accumulator i_mix_accumulator (
		.elem   (elem),
		.reset  (reset),
		.adc    (adc),
		.drive  (drive),
		.shift  (shift),
		.acc    (acc),
		.acc_stb(acc_stb)
	);

endmodule

`default_nettype wire

/* verification/qelem_tb.sv */
// qelem testbench with table loading, pulse stimulus, a cycle-indexed reference model and assertions
`default_nettype none
`include "qelem_defs.svh"

module qelem_tb import qelem_pkg::*; ;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_CYC = 4000; // about three times the setup and test cycles
	localparam int NEXP    = MAX_CYC + 64;
	localparam bit [4:0] SHIFTS [4] = '{5'd0, 5'd7, 5'd19, 5'd31};

	logic elem = 1'b0;
	logic reset = 1'b1;
	elem_cmd_t cmd;
	tbl_wr_t wr;
	slice_vec_t adc;
	logic [`QE_SHIFT_W-1:0] shift;
	drive_t drive;
	logic [`QE_NELEM-1:0] elem_busy;
	acc_t acc;
	logic acc_stb;

	int cyc = 0;
	int errors = 0;
	int tests = 0;
	slice_vec_t env_mem [2][256]; // host copy of the tables
	slice_vec_t freq_mem [2][256];
	slice_vec_t adc_tab [NEXP];
	slice_vec_t exp_data [NEXP];  // expected values by cycle
	bit exp_valid [NEXP];
	bit [1:0] exp_busy [NEXP];
	bit exp_stb [NEXP];
	acc_t exp_acc [NEXP];

	qelem_top i_qelem_top (.elem(elem), .reset(reset), .cmd(cmd), .wr(wr), .adc(adc),
		.shift(shift), .drive(drive), .elem_busy(elem_busy), .acc(acc), .acc_stb(acc_stb));

	initial forever #20 elem = ~elem;

	always @(posedge elem) begin
		cyc <= cyc + 1;
		if (cyc >= MAX_CYC) begin
			$display("timeout after %0d cycles", cyc);
			$display("Done: errors found");
			$finish;
		end
	end

	always @(negedge elem) adc <= adc_tab[cyc]; // adc of cycle n meets drive of cycle n

	a_valid: assert property (@(posedge elem) disable iff (reset) drive.valid == exp_valid[cyc])
		else begin
			errors++;
			$display("Fail drive.valid exp %h got %h", $sampled(exp_valid[cyc]),
				$sampled(drive.valid));
		end
	a_data: assert property (@(posedge elem) disable iff (reset)
		drive.valid |-> drive.data == exp_data[cyc])
		else begin
			errors++;
			$display("Fail drive.data exp %h got %h", $sampled(exp_data[cyc]),
				$sampled(drive.data));
		end
	a_busy: assert property (@(posedge elem) disable iff (reset) elem_busy == exp_busy[cyc])
		else begin
			errors++;
			$display("Fail elem_busy exp %h got %h", $sampled(exp_busy[cyc]),
				$sampled(elem_busy));
		end
	a_stb: assert property (@(posedge elem) disable iff (reset) acc_stb == exp_stb[cyc])
		else begin
			errors++;
			$display("Fail acc_stb exp %h got %h", $sampled(exp_stb[cyc]),
				$sampled(acc_stb));
		end
	a_acc: assert property (@(posedge elem) disable iff (reset) acc_stb |-> acc == exp_acc[cyc])
		else begin
			errors++;
			$display("Fail acc exp %h got %h", $sampled(exp_acc[cyc]),
				$sampled(acc));
		end

	// carrier multiply, q15 scale, amplitude, q15 scale again
	function automatic iq16_t mod_iq(iq16_t e, iq16_t c, logic signed [15:0] a);
		longint px;
		longint py;
		iq16_t r;
		px = longint'(e.x) * c.x - longint'(e.y) * c.y;
		py = longint'(e.x) * c.y + longint'(e.y) * c.x;
		px = ((px >>> 15) * a) >>> 15;
		py = ((py >>> 15) * a) >>> 15;
		r.x = px[15:0];
		r.y = py[15:0];
		return r;
	endfunction

	task automatic write_word(input int e, input bit tsel, input int addr, input slice_vec_t d);
		@(negedge elem);
		wr.we = 1'b1;
		wr.elem_sel = 1'(e);
		wr.tbl_sel = tbl_sel_e'(tsel);
		wr.addr = 8'(addr);
		wr.data = d;
		if (tsel) freq_mem[e][addr] = d;
		else env_mem[e][addr] = d;
	endtask

	// strobe sampled at edge c, drive from c+7, busy c+1 .. c+len+4
	task automatic send_cmd(input int e, input int st, input int len, input int fa,
		input logic signed [15:0] amp);
		int c;
		logic [7:0] a;
		iq16_t v;
		@(negedge elem);
		wr.we = 1'b0;
		cmd = '{env_start: 8'(st), env_length: 8'(len), freq_addr: 8'(fa), amp: amp,
			elem_sel: 1'(e), strobe: 1'b1};
		c = cyc + 1;
		for (int k = 0; k < len; k++) begin
			a = 8'(st + k);
			exp_valid[c + 7 + k] = 1'b1;
			for (int s = 0; s < `QE_NSLICE; s++) begin
				v = mod_iq(env_mem[e][a][s], freq_mem[e][fa][s], amp);
				exp_data[c + 7 + k][s].x = exp_data[c + 7 + k][s].x + v.x; // wraps
				exp_data[c + 7 + k][s].y = exp_data[c + 7 + k][s].y + v.y;
			end
		end
		for (int k = 1; len > 0 && k <= len + 4; k++) exp_busy[c + k][e] = 1'b1;
	endtask

	// one valid run of the drive, strobe 6 cycles after it ends
	task automatic expect_acc(input int from);
		int t;
		longint sx;
		longint sy;
		t = from;
		sx = 0;
		sy = 0;
		while (!exp_valid[t]) t++;
		while (exp_valid[t]) begin
			for (int s = 0; s < `QE_NSLICE; s++) begin
				sx += longint'(adc_tab[t][s].x) * exp_data[t][s].x
					- longint'(adc_tab[t][s].y) * exp_data[t][s].y;
				sy += longint'(adc_tab[t][s].x) * exp_data[t][s].y
					+ longint'(adc_tab[t][s].y) * exp_data[t][s].x;
			end
			t++;
		end
		exp_stb[t + 6] = 1'b1;
		exp_acc[t + 6].x = 32'(sx >>> shift);
		exp_acc[t + 6].y = 32'(sy >>> shift);
	endtask

	task automatic end_cmd_and_wait(input bit pulse);
		int from;
		from = cyc;
		@(negedge elem);
		cmd.strobe = 1'b0;
		if (pulse) expect_acc(from);
		repeat (2) @(negedge elem);
		while (elem_busy != 0) @(negedge elem);
		while (pulse && !acc_stb) @(negedge elem);
		repeat (2) @(negedge elem);
	endtask

	// zero length commands on both elements, neither may start a pulse
	task automatic park_both();
		send_cmd(0, 255, 0, 0, 16'sd0);
		send_cmd(1, 255, 0, 0, 16'sd0);
		end_cmd_and_wait(1'b0);
		repeat (8) @(negedge elem);
	endtask

	task automatic report(input string name);
		tests++;
		$display("test %0d %s finished, errors so far %0d", tests, name, errors);
	endtask

	task automatic random_pulse(input int e);
		send_cmd(e, $urandom_range(199), $urandom_range(40, 1), $urandom_range(15), 16'($urandom));
	endtask

	initial begin
		void'($urandom(32'hc692e351));
		cmd = '0;
		wr = '0;
		adc = '0;
		shift = '0;
		for (int i = 0; i < NEXP; i++) begin
			adc_tab[i] = {$urandom, $urandom};
			exp_data[i] = '0;
			exp_acc[i] = '0;
		end
		repeat (4) @(negedge elem);
		reset = 1'b0;
		for (int e = 0; e < 2; e++) begin
			for (int a = 0; a < 255; a++) write_word(e, 1'b0, a, {$urandom, $urandom});
			write_word(e, 1'b0, 255, '0);
			for (int a = 0; a < 16; a++) write_word(e, 1'b1, a, {$urandom, $urandom});
		end
		park_both();
		report("idle after reset");
		random_pulse(0);
		end_cmd_and_wait(1'b1);
		park_both();
		report("single element pulse");
		// one command bus, so the two starts are one cycle apart
		random_pulse(0);
		random_pulse(1);
		end_cmd_and_wait(1'b1);
		park_both();
		report("two elements summed");
		for (int a = 0; a < 32; a++) write_word(0, 1'b0, 100 + a, {$urandom, $urandom});
		send_cmd(0, 100, 32, 3, 16'sh4000);
		end_cmd_and_wait(1'b1);
		park_both();
		report("zero length and table rewrite");
		for (int i = 0; i < 4; i++) begin
			shift = SHIFTS[i];
			random_pulse(i % 2);
			end_cmd_and_wait(1'b1);
			park_both();
		end
		report("accumulator with shifts");
		send_cmd(1, 20, 1, 5, 16'sh7fff);
		end_cmd_and_wait(1'b1);
		park_both();
		report("busy window of a one sample pulse");
		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* qelem.f */
+incdir+include
src/qelem_pkg.sv
src/delay_line.sv
src/wave_table.sv
src/env_sequencer.sv
src/am_modulator.sv
src/pulse_element.sv
src/element_sum.sv
src/mix_accumulator.sv
src/qelem_top.sv
verification/qelem_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the qelem testbench with Verilator, pass only if the log shows the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -f qelem.f --top-module qelem_tb -o qelem_sim \
	> build.log 2>&1 &&
./obj_dir/qelem_sim > sim.log 2>&1 ||
{ echo "build or simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
